/* design/mem_bridge_pkg.sv */
// Memory bridge shared definitions
package mem_bridge_pkg;

    // Word address and data widths of the memory bus
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;

    // Both FIFO depths must be powers of two for the gray pointers
    localparam int CMD_FIFO_DEPTH = 16;
    localparam int RSP_FIFO_DEPTH = 8;

    // Requests the bridge still takes after master waitrequest rises
    localparam int ALMFULL_THRESHOLD = 2;

    // Free-space counts need one bit more than the index to hold a full DEPTH
    localparam int CMD_SPACE_WIDTH = $clog2(CMD_FIFO_DEPTH) + 1;
    localparam int RSP_SPACE_WIDTH = $clog2(RSP_FIFO_DEPTH) + 1;

    // One bus request, the same shape on the master and the slave side
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0] writedata;
        logic [BE_WIDTH-1:0]   byteenable;
    } mem_req_t;

    // One command FIFO entry
    // A read is an entry with is_write low and its data fields ignored
    typedef struct packed {
        logic                  is_write;
        logic [ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0] writedata;
        logic [BE_WIDTH-1:0]   byteenable;
    } mem_cmd_t;

    // One read response
    typedef struct packed {
        logic [DATA_WIDTH-1:0] readdata;
    } mem_rsp_t;

endpackage

/* design/async_fifo.sv */
// Dual-clock gray pointer FIFO
`timescale 1ns/100ps

module async_fifo
#(
    parameter int DEPTH = 16,
    parameter int WIDTH = 32
)
(
    // Write side
    input  logic                     wr_clk,
    input  logic                     rst_n,
    input  logic                     wr_push,
    input  logic [WIDTH-1:0]         wr_data,
    output logic [$clog2(DEPTH):0]   wr_space,

    // Read side
    input  logic                     rd_clk,
    input  logic                     rd_pop,
    output logic [WIDTH-1:0]         rd_data,
    output logic                     rd_valid
);

    // Entry storage, indexed by the low pointer bits
    logic [WIDTH-1:0]       mem [DEPTH];

    logic [1:0]             wr_rst_sync;
    logic                   wr_rst_n;
    logic                   wr_accept;
    logic [$clog2(DEPTH):0] wr_bin;
    logic [$clog2(DEPTH):0] wr_bin_next;
    logic [$clog2(DEPTH):0] wr_gray;
    logic [$clog2(DEPTH):0] rd_gray_s1;
    logic [$clog2(DEPTH):0] rd_gray_s2;
    logic [$clog2(DEPTH):0] rd_bin_wr;

    logic [1:0]             rd_rst_sync;
    logic                   rd_rst_n;
    logic [$clog2(DEPTH):0] rd_bin;
    logic [$clog2(DEPTH):0] rd_bin_next;
    logic [$clog2(DEPTH):0] rd_gray;
    logic [$clog2(DEPTH):0] wr_gray_s1;
    logic [$clog2(DEPTH):0] wr_gray_s2;

    // Turns a synchronized gray pointer back into binary
    function automatic logic [$clog2(DEPTH):0] gray_to_bin(input logic [$clog2(DEPTH):0] gray);
        logic [$clog2(DEPTH):0] bin;
        bin[$clog2(DEPTH)] = gray[$clog2(DEPTH)];
        for (int i = $clog2(DEPTH) - 1; i >= 0; i--)
        begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // Reset asserts at once in each domain and releases on that domain's clock
    always_ff @(posedge wr_clk or negedge rst_n)
    begin
        if (!rst_n)
            wr_rst_sync <= 2'b00;
        else
            wr_rst_sync <= {wr_rst_sync[0], 1'b1};
    end

    always_ff @(posedge rd_clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_rst_sync <= 2'b00;
        else
            rd_rst_sync <= {rd_rst_sync[0], 1'b1};
    end

    assign wr_rst_n = wr_rst_sync[1];
    assign rd_rst_n = rd_rst_sync[1];

    // A push into a full FIFO is dropped so the pointers never pass each other
    assign wr_accept   = wr_push && (wr_space != '0);
    assign wr_bin_next = wr_bin + ($clog2(DEPTH) + 1)'(wr_accept);
    assign rd_bin_wr   = gray_to_bin(rd_gray_s2);

    always_ff @(posedge wr_clk)
    begin
        if (wr_accept)
            mem[wr_bin[$clog2(DEPTH)-1:0]] <= wr_data;
    end

    // Free space is registered from the next write pointer, so it already
    // counts this cycle's push and reads zero while the write side is in reset
    always_ff @(posedge wr_clk or negedge wr_rst_n)
    begin
        if (!wr_rst_n)
        begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            wr_space   <= '0;
        end
        else
        begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            wr_space   <= ($clog2(DEPTH) + 1)'(DEPTH) - (wr_bin_next - rd_bin_wr);
        end
    end

    // Head entry is shown as soon as the synchronized write pointer moves past it
    assign rd_valid    = (rd_gray != wr_gray_s2);
    assign rd_data     = mem[rd_bin[$clog2(DEPTH)-1:0]];
    assign rd_bin_next = rd_bin + ($clog2(DEPTH) + 1)'(rd_pop && rd_valid);

    always_ff @(posedge rd_clk or negedge rd_rst_n)
    begin
        if (!rd_rst_n)
        begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end
        else
        begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

endmodule

/* design/cmd_decode.sv */
// Master side command decode
`timescale 1ns/100ps

module cmd_decode
(
    input  logic                                mem_master,
    input  logic                                rst_n,
    input  mem_bridge_pkg::mem_req_t            master_req,
    input  logic [mem_bridge_pkg::CMD_SPACE_WIDTH-1:0] cmd_space,
    output logic                                cmd_push,
    output mem_bridge_pkg::mem_cmd_t            cmd_entry,
    output logic                                master_waitrequest
);

    import mem_bridge_pkg::*;

    logic wait_next;

    // Every presented request is taken, waitrequest only asks the master to stop
    assign cmd_push = master_req.read || master_req.write;

    // Write wins if a master ever raises both strobes together
    always_comb
    begin
        cmd_entry.is_write   = master_req.write;
        cmd_entry.address    = master_req.address;
        cmd_entry.writedata  = master_req.writedata;
        cmd_entry.byteenable = master_req.byteenable;
    end

    // Free space after this cycle's push decides the stop signal
    // The FIFO count already holds every older push but not the current one
    assign wait_next = (cmd_space <=
                        CMD_SPACE_WIDTH'(ALMFULL_THRESHOLD) + CMD_SPACE_WIDTH'(cmd_push));

    // Registered almost-full stop, high through reset
    // The FIFO reports no space while its write side is still in reset,
    // so waitrequest also stays high until the FIFO can take entries
    always_ff @(posedge mem_master or negedge rst_n)
    begin
        if (!rst_n)
        begin
            master_waitrequest <= 1'b1;
        end
        else
        begin
            master_waitrequest <= wait_next;
        end
    end

endmodule

/* design/cmd_execute.sv */
// Slave side command execute
`timescale 1ns/100ps

module cmd_execute
(
    input  logic                                mem_slave,
    input  logic                                rst_n,
    input  mem_bridge_pkg::mem_cmd_t            cmd_entry,
    input  logic                                cmd_valid,
    output logic                                cmd_pop,
    input  logic [mem_bridge_pkg::RSP_SPACE_WIDTH-1:0] rsp_space,
    input  logic                                slave_rsp_valid,
    output mem_bridge_pkg::mem_req_t            slave_req,
    input  logic                                slave_waitrequest
);

    import mem_bridge_pkg::*;

    // Control flags of the output register
    logic                       req_read;
    logic                       req_write;

    // Payload of the output register
    logic [ADDR_WIDTH-1:0]      req_address;
    logic [DATA_WIDTH-1:0]      req_writedata;
    logic [BE_WIDTH-1:0]        req_byteenable;

    logic                       req_done;
    logic                       reg_free;
    logic [RSP_SPACE_WIDTH-1:0] outstanding;
    logic [RSP_SPACE_WIDTH-1:0] claimed;
    logic                       credit_ok;

    // A request completes on the first edge where the slave lowers waitrequest
    assign req_done = (req_read || req_write) && !slave_waitrequest;
    assign reg_free = !(req_read || req_write) || req_done;

    // Slots claimed are the completed reads still waiting for data plus a read
    // sitting in the output register, which is not counted yet
    assign claimed   = outstanding + RSP_SPACE_WIDTH'(req_read);
    assign credit_ok = (rsp_space > claimed);

    // Writes never need a response slot
    assign cmd_pop = cmd_valid && reg_free && (cmd_entry.is_write || credit_ok);

    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_read  <= 1'b0;
            req_write <= 1'b0;
        end
        else if (cmd_pop)
        begin
            req_read  <= !cmd_entry.is_write;
            req_write <= cmd_entry.is_write;
        end
        else if (req_done)
        begin
            req_read  <= 1'b0;
            req_write <= 1'b0;
        end
    end

    // Payload only moves on a load, so it holds steady under waitrequest
    always_ff @(posedge mem_slave)
    begin
        if (cmd_pop)
        begin
            req_address    <= cmd_entry.address;
            req_writedata  <= cmd_entry.writedata;
            req_byteenable <= cmd_entry.byteenable;
        end
    end

    // Reads accepted by the slave whose data has not come back yet
    always_ff @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
            outstanding <= '0;
        else
            outstanding <= outstanding + RSP_SPACE_WIDTH'(req_done && req_read)
                           - RSP_SPACE_WIDTH'(slave_rsp_valid);
    end

    always_comb
    begin
        slave_req.read       = req_read;
        slave_req.write      = req_write;
        slave_req.address    = req_address;
        slave_req.writedata  = req_writedata;
        slave_req.byteenable = req_byteenable;
    end

endmodule

/* design/rsp_result.sv */
// Read response return path
`timescale 1ns/100ps

module rsp_result
(
    input  logic                                mem_master,
    input  logic                                mem_slave,
    input  logic                                rst_n,
    input  mem_bridge_pkg::mem_rsp_t            slave_rsp,
    input  logic                                slave_rsp_valid,
    output logic [mem_bridge_pkg::RSP_SPACE_WIDTH-1:0] rsp_space,
    output mem_bridge_pkg::mem_rsp_t            master_rsp,
    output logic                                master_rsp_valid
);

    import mem_bridge_pkg::*;

    mem_rsp_t fifo_rsp;
    logic     fifo_valid;

    // Read credits upstream guarantee a free slot for every returned word
    async_fifo
    #(
        .DEPTH (RSP_FIFO_DEPTH),
        .WIDTH ($bits(mem_rsp_t))
    )
    rsp_fifo
    (
        .wr_clk   (mem_slave),
        .rst_n    (rst_n),
        .wr_push  (slave_rsp_valid),
        .wr_data  (slave_rsp),
        .wr_space (rsp_space),
        .rd_clk   (mem_master),
        .rd_pop   (fifo_valid),
        .rd_data  (fifo_rsp),
        .rd_valid (fifo_valid)
    );

    // The master cannot stall responses, so one entry drains every cycle
    always_ff @(posedge mem_master or negedge rst_n)
    begin
        if (!rst_n)
            master_rsp_valid <= 1'b0;
        else
            master_rsp_valid <= fifo_valid;
    end

    // Data register only loads with a valid entry
    always_ff @(posedge mem_master)
    begin
        if (fifo_valid)
            master_rsp <= fifo_rsp;
    end

endmodule

/* design/mem_bridge_top.sv */
// Memory clock crossing bridge
`timescale 1ns/100ps

module mem_bridge_top
(
    // Master side, mem_master domain
    input  logic                     mem_master,
    input  logic                     rst_n,
    input  mem_bridge_pkg::mem_req_t master_req,
    output logic                     master_waitrequest,
    output mem_bridge_pkg::mem_rsp_t master_rsp,
    output logic                     master_rsp_valid,

    // Slave side, mem_slave domain
    input  logic                     mem_slave,
    output mem_bridge_pkg::mem_req_t slave_req,
    input  logic                     slave_waitrequest,
    input  mem_bridge_pkg::mem_rsp_t slave_rsp,
    input  logic                     slave_rsp_valid
);

    import mem_bridge_pkg::*;

    // Command path between decode and execute
    logic                       cmd_push;
    mem_cmd_t                   cmd_wr_entry;
    logic [CMD_SPACE_WIDTH-1:0] cmd_space;
    mem_cmd_t                   cmd_rd_entry;
    logic                       cmd_valid;
    logic                       cmd_pop;

    // Response FIFO free space, used for read credits
    logic [RSP_SPACE_WIDTH-1:0] rsp_space;

    cmd_decode u_cmd_decode
    (
        .mem_master         (mem_master),
        .rst_n              (rst_n),
        .master_req         (master_req),
        .cmd_space          (cmd_space),
        .cmd_push           (cmd_push),
        .cmd_entry          (cmd_wr_entry),
        .master_waitrequest (master_waitrequest)
    );

    // Commands cross from mem_master to mem_slave in issue order
    async_fifo
    #(
        .DEPTH (CMD_FIFO_DEPTH),
        .WIDTH ($bits(mem_cmd_t))
    )
    cmd_fifo
    (
        .wr_clk   (mem_master),
        .rst_n    (rst_n),
        .wr_push  (cmd_push),
        .wr_data  (cmd_wr_entry),
        .wr_space (cmd_space),
        .rd_clk   (mem_slave),
        .rd_pop   (cmd_pop),
        .rd_data  (cmd_rd_entry),
        .rd_valid (cmd_valid)
    );

    cmd_execute u_cmd_execute
    (
        .mem_slave         (mem_slave),
        .rst_n             (rst_n),
        .cmd_entry         (cmd_rd_entry),
        .cmd_valid         (cmd_valid),
        .cmd_pop           (cmd_pop),
        .rsp_space         (rsp_space),
        .slave_rsp_valid   (slave_rsp_valid),
        .slave_req         (slave_req),
        .slave_waitrequest (slave_waitrequest)
    );

    rsp_result u_rsp_result
    (
        .mem_master       (mem_master),
        .mem_slave        (mem_slave),
        .rst_n            (rst_n),
        .slave_rsp        (slave_rsp),
        .slave_rsp_valid  (slave_rsp_valid),
        .rsp_space        (rsp_space),
        .master_rsp       (master_rsp),
        .master_rsp_valid (master_rsp_valid)
    );

endmodule

/* test/mem_slave_model.sv */
// Behavioral memory slave
`timescale 1ns/100ps

module mem_slave_model
(
    input  logic                     mem_slave,
    input  logic                     rst_n,
    input  mem_bridge_pkg::mem_req_t slave_req,
    input  logic [3:0]               wait_level,
    input  logic [4:0]               lat_extra,
    output logic                     slave_waitrequest,
    output mem_bridge_pkg::mem_rsp_t slave_rsp,
    output logic                     slave_rsp_valid
);

    import mem_bridge_pkg::*;

    // Only the low six address bits select a word, so higher addresses alias
    logic [DATA_WIDTH-1:0] mem [64];
    logic [DATA_WIDTH-1:0] rd_data_q [$];
    int                    rd_due_q [$];
    int                    cycle;
    int                    last_due;
    int                    due;
    int                    seed;

    initial
    begin
        seed = 32'h484e;
        for (int i = 0; i < 64; i++)
            mem[i] = {2'b01, 6'(i), 2'b10, ~6'(i), 16'hc35a ^ 16'(i)};
    end

    always @(posedge mem_slave or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slave_waitrequest <= 1'b1;
            slave_rsp_valid   <= 1'b0;
            cycle    = 0;
            last_due = 0;
            rd_data_q.delete();
            rd_due_q.delete();
        end
        else
        begin
            cycle = cycle + 1;
            // A request is taken on the edge where waitrequest was low
            if ((slave_req.read || slave_req.write) && !slave_waitrequest)
            begin
                if (slave_req.write)
                begin
                    for (int b = 0; b < BE_WIDTH; b++)
                        if (slave_req.byteenable[b])
                            mem[slave_req.address[5:0]][8*b +: 8] = slave_req.writedata[8*b +: 8];
                end
                else
                begin
                    // Latency of 1 to 6 cycles plus any extra, never overtaking an older read
                    due = cycle + 1 + int'($unsigned($random(seed)) % 6) + int'(lat_extra);
                    if (due <= last_due)
                        due = last_due + 1;
                    last_due = due;
                    rd_data_q.push_back(mem[slave_req.address[5:0]]);
                    rd_due_q.push_back(due);
                end
            end
            // Waitrequest is high with a chance of wait_level in 16
            slave_waitrequest <= (($unsigned($random(seed)) % 16) < wait_level);
            if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle)
            begin
                slave_rsp_valid    <= 1'b1;
                slave_rsp.readdata <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end
            else
                slave_rsp_valid <= 1'b0;
        end
    end

endmodule

/* test/mem_bridge_tb.sv */
// Memory bridge testbench
`timescale 1ns/100ps

module mem_bridge_tb;

    import mem_bridge_pkg::*;

    // Operation counts per test, which also set the cycle limit of the run
    localparam int ORDER_OPS   = 20;
    localparam int MERGE_OPS   = 4;
    localparam int MIX_OPS     = 500;
    localparam int FILL_OPS    = 40;
    localparam int LAT_OPS     = 40;
    localparam int TOTAL_OPS   = ORDER_OPS + MERGE_OPS + MIX_OPS + FILL_OPS + LAT_OPS;
    localparam int CYCLE_LIMIT = TOTAL_OPS * 60;

    logic                  mem_master;
    logic                  mem_slave;
    logic                  rst_n;
    mem_req_t              master_req;
    logic                  master_waitrequest;
    mem_rsp_t              master_rsp;
    logic                  master_rsp_valid;
    mem_req_t              slave_req;
    logic                  slave_waitrequest;
    mem_rsp_t              slave_rsp;
    logic                  slave_rsp_valid;
    logic [3:0]            wait_level;
    logic [4:0]            lat_extra;

    // Reference memory and what the DUT still owes
    logic [DATA_WIDTH-1:0] ref_mem [64];
    mem_req_t              exp_req [$];
    mem_rsp_t              exp_rsp [$];
    int                    seed = 32'h484e;
    int                    errors;
    int                    checks;
    int                    cycles;
    int                    slave_writes;
    int                    wait_hits;
    int                    test_errors;
    int                    writes_before;
    logic                  wait_seen;

    // Reads taken by the slave whose data has not reached the master yet
    int                    reads_in_flight;

    mem_bridge_top UUT
    (
        .mem_master         (mem_master),
        .rst_n              (rst_n),
        .master_req         (master_req),
        .master_waitrequest (master_waitrequest),
        .master_rsp         (master_rsp),
        .master_rsp_valid   (master_rsp_valid),
        .mem_slave          (mem_slave),
        .slave_req          (slave_req),
        .slave_waitrequest  (slave_waitrequest),
        .slave_rsp          (slave_rsp),
        .slave_rsp_valid    (slave_rsp_valid)
    );

    mem_slave_model u_slave_model
    (
        .mem_slave         (mem_slave),
        .rst_n             (rst_n),
        .slave_req         (slave_req),
        .wait_level        (wait_level),
        .lat_extra         (lat_extra),
        .slave_waitrequest (slave_waitrequest),
        .slave_rsp         (slave_rsp),
        .slave_rsp_valid   (slave_rsp_valid)
    );

    initial
    begin
        mem_master = 1'b0;
        forever #10 mem_master = ~mem_master;
    end

    initial
    begin
        mem_slave = 1'b0;
        forever #7 mem_slave = ~mem_slave;
    end

    // Same start contents as the slave memory
    function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [5:0] idx);
        return {2'b01, idx, 2'b10, ~idx, 16'hc35a ^ {10'h000, idx}};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                          input logic [DATA_WIDTH-1:0] new_word,
                                                          input logic [BE_WIDTH-1:0] be);
        logic [DATA_WIDTH-1:0] result;
        result = old_word;
        for (int b = 0; b < BE_WIDTH; b++)
            if (be[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        return result;
    endfunction

    task automatic check_req(input mem_req_t actual, input mem_req_t expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH at %0t: slave request %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_rsp(input mem_rsp_t actual, input mem_rsp_t expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH at %0t: read data %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Kind 0 picks read or write at random, 1 always writes, 2 always reads
    task automatic make_req(input int kind, output mem_req_t req);
        logic [31:0] r;
        r = $random(seed);
        req.write      = (kind == 1) || (kind == 0 && r[0]);
        req.read       = !req.write;
        req.address    = ADDR_WIDTH'($random(seed));
        req.writedata  = DATA_WIDTH'($random(seed));
        req.byteenable = BE_WIDTH'($random(seed));
    endtask

    // Drives one request and books what it should cause
    task automatic issue_req(input mem_req_t req);
        logic     taken;
        mem_rsp_t rsp;
        taken = 1'b0;
        while (!taken)
        begin
            @(posedge mem_master);
            #2;
            // The master stops in the cycle after it first sees waitrequest high
            if (!wait_seen)
            begin
                master_req = req;
                taken      = 1'b1;
                exp_req.push_back(req);
                if (req.write)
                    ref_mem[req.address[5:0]] = merge_bytes(ref_mem[req.address[5:0]],
                                                            req.writedata, req.byteenable);
                else
                begin
                    rsp.readdata = ref_mem[req.address[5:0]];
                    exp_rsp.push_back(rsp);
                end
            end
            else
                master_req = '0;
            if (master_waitrequest)
                wait_hits++;
            wait_seen = master_waitrequest;
        end
    endtask

    task automatic run_random(input int count, input int kind);
        mem_req_t req;
        for (int n = 0; n < count; n++)
        begin
            make_req(kind, req);
            issue_req(req);
        end
    endtask

    // Idles the bus until every booked request and response has shown up
    task automatic wait_drain();
        @(posedge mem_master);
        #2;
        master_req = '0;
        wait_seen  = master_waitrequest;
        while (exp_req.size() != 0 || exp_rsp.size() != 0)
            @(posedge mem_master);
        repeat (4) @(posedge mem_master);
        #2;
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors)
            $display("%s: done, no errors", name);
        else
            $display("%s: done, %0d errors", name, errors - start_errors);
    endtask

    // Sampled mid-cycle, where the values the slave takes at the next edge are stable
    always @(negedge mem_slave)
    begin
        if (rst_n && (slave_req.read || slave_req.write) && !slave_waitrequest)
        begin
            if (slave_req.write)
                slave_writes++;
            // A read may only go out when a response FIFO slot is free for it
            if (slave_req.read)
            begin
                reads_in_flight++;
                if (reads_in_flight > RSP_FIFO_DEPTH)
                begin
                    errors++;
                    $display("Error at %0t: %0d reads in flight, more than the response FIFO holds",
                             $time, reads_in_flight);
                end
            end
            if (exp_req.size() == 0)
            begin
                errors++;
                $display("Error at %0t: slave request seen with none outstanding", $time);
            end
            else
                check_req(slave_req, exp_req.pop_front());
        end
    end

    always @(negedge mem_master)
    begin
        if (master_rsp_valid)
        begin
            reads_in_flight--;
            if (exp_rsp.size() == 0)
            begin
                errors++;
                $display("Error at %0t: read response seen with no read outstanding", $time);
            end
            else
                check_rsp(master_rsp, exp_rsp.pop_front());
        end
    end

    always @(posedge mem_master)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: run did not end within %0d mem_master cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        mem_req_t req;
        rst_n           = 1'b0;
        master_req      = '0;
        wait_level      = '0;
        lat_extra       = '0;
        wait_seen       = 1'b1;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        slave_writes    = 0;
        wait_hits       = 0;
        reads_in_flight = 0;
        for (int i = 0; i < 64; i++)
            ref_mem[i] = fill_word(6'(i));

        // Test 1 covers both reset cycles and the first cycles after release
        test_errors = errors;
        for (int n = 0; n < 4; n++)
        begin
            if (n == 2)
            begin
                @(posedge mem_master);
                #2;
                rst_n = 1'b1;
            end
            @(negedge mem_master);
            check_flag(master_waitrequest, 1'b1, "master_waitrequest");
            check_flag(master_rsp_valid, 1'b0, "master_rsp_valid");
            check_flag(slave_req.read || slave_req.write, 1'b0, "slave request strobe");
        end
        report_test("Test 1 reset state", test_errors);

        test_errors = errors;
        run_random(ORDER_OPS, 0);
        wait_drain();
        report_test("Test 2 request order", test_errors);

        // Two partial writes to one word, each followed by a read of it
        test_errors = errors;
        make_req(1, req);
        req.byteenable = 4'b1010;
        issue_req(req);
        req.read  = 1'b1;
        req.write = 1'b0;
        issue_req(req);
        req.read       = 1'b0;
        req.write      = 1'b1;
        req.writedata  = ~req.writedata;
        req.byteenable = 4'b0101;
        issue_req(req);
        req.read  = 1'b1;
        req.write = 1'b0;
        issue_req(req);
        wait_drain();
        report_test("Test 3 byte enable merge", test_errors);

        test_errors = errors;
        wait_level  = 4'd4;
        run_random(MIX_OPS, 0);
        wait_drain();
        report_test("Test 4 random mix", test_errors);

        // Slave stalls almost every cycle, so the command FIFO backs up
        test_errors   = errors;
        wait_level    = 4'd15;
        wait_hits     = 0;
        writes_before = slave_writes;
        run_random(FILL_OPS, 1);
        wait_drain();
        if (wait_hits == 0)
        begin
            errors++;
            $display("Error: master_waitrequest never rose under slave back-pressure");
        end
        if (slave_writes - writes_before != FILL_OPS)
        begin
            errors++;
            $display("Error: slave saw %0d writes, %0d were issued",
                     slave_writes - writes_before, FILL_OPS);
        end
        report_test("Test 5 command back-pressure", test_errors);

        // Long read latency leans on the read credits
        test_errors = errors;
        wait_level  = 4'd0;
        lat_extra   = 5'd24;
        run_random(LAT_OPS, 2);
        wait_drain();
        report_test("Test 6 long read latency", test_errors);

        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* mem_bridge.f */
design/mem_bridge_pkg.sv
design/async_fifo.sv
design/cmd_decode.sv
design/cmd_execute.sv
design/rsp_result.sv
design/mem_bridge_top.sv
test/mem_slave_model.sv
test/mem_bridge_tb.sv
